// File: btac.sv
`timescale 1ns/1ps

module btac (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear,
  input  logic        stall,
  input  logic [31:0] get_pc0,
  input  logic [31:0] get_pc1,
  input  logic [31:0] upd_pc0,
  input  logic [31:0] upd_npc0,
  input  logic [31:0] upd_addr0,
  input  logic        upd_jump0,
  input  logic        upd_branch0,
  input  logic        upd_jal0,
  input  logic [31:0] upd_pc1,
  input  logic [31:0] upd_npc1,
  input  logic [31:0] upd_addr1,
  input  logic        upd_jump1,
  input  logic        upd_branch1,
  input  logic        upd_jal1,
  input  logic        fetch_taken,
  input  logic [31:0] fetch_taddr,
  input  logic [31:0] fetch_tpc,
  input  logic [31:0] fetch_tnpc,
  input  logic        decode_taken,
  input  logic [31:0] decode_taddr,
  input  logic [31:0] decode_tpc,
  input  logic [31:0] decode_tnpc,
  input  logic        issue_taken,
  input  logic [31:0] issue_taddr,
  input  logic [31:0] issue_tpc,
  input  logic [31:0] issue_tnpc,
  input  logic        execute_taken,
  input  logic [31:0] execute_taddr,
  input  logic [31:0] execute_tpc,
  input  logic [31:0] execute_tnpc,
  input  logic        memory_taken,
  input  logic [31:0] memory_taddr,
  input  logic [31:0] memory_tpc,
  input  logic [31:0] memory_tnpc,
  output logic        pred_branch,
  output logic [31:0] pred_baddr,
  output logic [31:0] pred_pc,
  output logic [31:0] pred_npc,
  output logic        pred_miss,
  output logic [31:0] pred_maddr
);

  logic [btac_pkg::btb_index_width-1:0] raddr0;
  logic [btac_pkg::btb_index_width-1:0] raddr1;
  logic [btac_pkg::btb_index_width-1:0] waddr;
  logic                                 wen;
  logic [btac_pkg::entry_width-1:0]     wdata;
  logic [btac_pkg::entry_width-1:0]     rdata0;
  logic [btac_pkg::entry_width-1:0]     rdata1;
  logic [31:0]                          pc0_q;
  logic [31:0]                          pc1_q;
  logic                                 hit0;
  logic                                 hit1;
  logic [31:0]                          sel_baddr;
  logic [31:0]                          sel_pc;
  logic [31:0]                          sel_npc;
  logic                                 cand_taken;
  logic [31:0]                          cand_taddr;
  logic [31:0]                          cand_tpc;
  logic [31:0]                          cand_tnpc;
  btac_pkg::tracker_state_t             trk_state;
  btac_pkg::resolve_kind_t              kind;

  btac_ctrl u_ctrl (.*);                // Fetch side and table write

  btb_ram u_ram (.*);

  btb_lookup u_lookup (.*);

  // Miss path, resolved in the update cycle
  taken_tracker u_tracker (.*, .state (trk_state));

  miss_resolver u_resolver (.*, .state (trk_state));

endmodule

// File: btac_assert.sv
`timescale 1ns/1ps

module btac_assert (
  input logic                    clock,
  input logic                    reset,
  input logic                    clear,
  input logic                    stall,
  input logic                    wen,
  input logic                    pred_branch,
  input logic                    pred_miss,
  input btac_pkg::resolve_kind_t kind
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flush and stall masking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  miss_off_in_clear: assert property (@(posedge clock) disable iff (!reset)
    clear |-> !pred_miss) else $error("pred_miss high during clear");

  branch_off_in_stall: assert property (@(posedge clock) disable iff (!reset)
    stall |-> !pred_branch) else $error("pred_branch high during stall");

  no_write_in_clear: assert property (@(posedge clock) disable iff (!reset)
    clear |-> !wen) else $error("Table write during clear");

  // Only a confirmed target resolves without a miss
  verdict_has_miss: assert property (@(posedge clock) disable iff (!reset)
    (kind != btac_pkg::res_none) |-> (pred_miss || kind == btac_pkg::res_confirm))
    else $error("Verdict %0d without pred_miss", kind);

endmodule

bind btac btac_assert u_assert (
  .clock       (clock),
  .reset       (reset),
  .clear       (clear),
  .stall       (stall),
  .wen         (wen),
  .pred_branch (pred_branch),
  .pred_miss   (pred_miss),
  .kind        (kind)
);

// File: btac_ctrl.sv
`timescale 1ns/1ps

module btac_ctrl (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear,
  input  logic        stall,
  input  logic [31:0] get_pc0,
  input  logic [31:0] get_pc1,
  input  logic [31:0] upd_pc0,
  input  logic [31:0] upd_pc1,
  input  logic [31:0] upd_npc0,
  input  logic [31:0] upd_npc1,
  input  logic [31:0] upd_addr0,
  input  logic [31:0] upd_addr1,
  input  logic        upd_jump0,
  input  logic        upd_jump1,
  input  logic        upd_branch0,
  input  logic        upd_branch1,
  input  logic        upd_jal0,
  input  logic        upd_jal1,
  input  logic        hit0,
  input  logic        hit1,
  input  logic [31:0] sel_baddr,
  input  logic [31:0] sel_pc,
  input  logic [31:0] sel_npc,
  output logic [5:0]  raddr0,
  output logic [5:0]  raddr1,
  output logic [5:0]  waddr,
  output logic        wen,
  output logic [95:0] wdata,
  output logic [31:0] pc0_q,
  output logic [31:0] pc1_q,
  output logic        pred_branch,
  output logic [31:0] pred_baddr,
  output logic [31:0] pred_pc,
  output logic [31:0] pred_npc
);

  logic write0;
  logic write1;
  logic predict;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
    end else if (!clear) begin
      pc0_q <= get_pc0;
      pc1_q <= get_pc1;
    end
  end

  // Clear holds the old index so the table output stays put
  assign raddr0 = clear ? pc0_q[btac_pkg::btb_index_low +: btac_pkg::btb_index_width]
                        : get_pc0[btac_pkg::btb_index_low +: btac_pkg::btb_index_width];
  assign raddr1 = clear ? pc1_q[btac_pkg::btb_index_low +: btac_pkg::btb_index_width]
                        : get_pc1[btac_pkg::btb_index_low +: btac_pkg::btb_index_width];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table write from a resolved jump
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign write0 = (upd_jal0 || upd_branch0) && upd_jump0;
  assign write1 = (upd_jal1 || upd_branch1) && upd_jump1;
  assign wen    = !clear && (write0 || write1);

  // Slot 0 preferred
  assign waddr = write0 ? upd_pc0[btac_pkg::btb_index_low +: btac_pkg::btb_index_width]
                        : upd_pc1[btac_pkg::btb_index_low +: btac_pkg::btb_index_width];

  always_comb begin
    wdata = '0;
    if (write0) begin
      wdata[btac_pkg::target_lsb +: btac_pkg::word_width] = upd_addr0;
      wdata[btac_pkg::pc_lsb +: btac_pkg::word_width]     = upd_pc0;
      wdata[btac_pkg::npc_lsb +: btac_pkg::word_width]    = upd_npc0;
    end else begin
      wdata[btac_pkg::target_lsb +: btac_pkg::word_width] = upd_addr1;
      wdata[btac_pkg::pc_lsb +: btac_pkg::word_width]     = upd_pc1;
      wdata[btac_pkg::npc_lsb +: btac_pkg::word_width]    = upd_npc1;
    end
  end

  assign predict     = !(stall || clear);
  assign pred_branch = predict && (hit0 || hit1);
  assign pred_baddr  = predict ? sel_baddr : '0;
  assign pred_pc     = predict ? sel_pc : '0;
  assign pred_npc    = predict ? sel_npc : '0;

endmodule

// File: btac_pkg.sv
package btac_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int btb_entries     = 64;
  localparam int btb_index_width = 6;
  localparam int btb_index_low   = 2;   // Word aligned pcs
  localparam int entry_width     = 96;
  localparam int word_width      = 32;

  // Word positions inside one entry, high to low
  localparam int target_lsb = 64;
  localparam int pc_lsb     = 32;
  localparam int npc_lsb    = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State and verdict encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic {
    trk_idle,
    trk_armed                           // Taken branch in flight
  } tracker_state_t;

  typedef enum logic [2:0] {
    res_none,
    res_confirm,                        // Target as predicted
    res_wrong_target,
    res_not_taken,
    res_unpredicted                     // Jump with no record
  } resolve_kind_t;

endpackage

// File: btac_tb.sv
`timescale 1ns/1ps

module btac_tb;

  logic        clock;
  logic        reset;
  logic        clear;
  logic        stall;
  logic [31:0] get_pc0, get_pc1;
  logic [31:0] upd_pc0, upd_npc0, upd_addr0, upd_pc1, upd_npc1, upd_addr1;
  logic        upd_jump0, upd_branch0, upd_jal0, upd_jump1, upd_branch1, upd_jal1;
  logic        fetch_taken, decode_taken, issue_taken, execute_taken, memory_taken;
  logic [31:0] fetch_taddr, fetch_tpc, fetch_tnpc, decode_taddr, decode_tpc, decode_tnpc;
  logic [31:0] issue_taddr, issue_tpc, issue_tnpc, execute_taddr, execute_tpc, execute_tnpc;
  logic [31:0] memory_taddr, memory_tpc, memory_tnpc;
  logic        pred_branch, pred_miss;
  logic [31:0] pred_baddr, pred_pc, pred_npc, pred_maddr;

  int          test_num;
  logic [31:0] clr_f, stl_f, flags0, flags1, mask;      // Record fields besides DUT inputs
  logic [31:0] sa, sa_taddr, sa_tpc, sa_tnpc, sb, sb_taddr, sb_tpc, sb_tnpc;
  logic [31:0] exp_branch, exp_baddr, exp_pc, exp_npc, exp_miss, exp_maddr;

  string lines[$];
  int    limit = 0;
  int    cycles = 0;
  int    checks = 0;
  int    errors = 0;
  int    tests = 0;
  int    test_checks = 0;
  int    test_errors = 0;

  btac u_btac (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic idle_inputs();
    {clear, stall, get_pc0, get_pc1} = '0;
    {upd_pc0, upd_npc0, upd_addr0, upd_jump0, upd_branch0, upd_jal0} = '0;
    {upd_pc1, upd_npc1, upd_addr1, upd_jump1, upd_branch1, upd_jal1} = '0;
    {fetch_taken, fetch_taddr, fetch_tpc, fetch_tnpc} = '0;
    {decode_taken, decode_taddr, decode_tpc, decode_tnpc} = '0;
    {issue_taken, issue_taddr, issue_tpc, issue_tnpc} = '0;
    {execute_taken, execute_taddr, execute_tpc, execute_tnpc} = '0;
    {memory_taken, memory_taddr, memory_tpc, memory_tnpc} = '0;
  endtask

  task automatic report_stage(input logic [31:0] stage, input logic [31:0] taddr,
                              input logic [31:0] tpc, input logic [31:0] tnpc);
    case (stage)
      0: {fetch_taken, fetch_taddr, fetch_tpc, fetch_tnpc} = {1'b1, taddr, tpc, tnpc};
      1: {decode_taken, decode_taddr, decode_tpc, decode_tnpc} = {1'b1, taddr, tpc, tnpc};
      2: {issue_taken, issue_taddr, issue_tpc, issue_tnpc} = {1'b1, taddr, tpc, tnpc};
      3: {execute_taken, execute_taddr, execute_tpc, execute_tnpc} = {1'b1, taddr, tpc, tnpc};
      4: {memory_taken, memory_taddr, memory_tpc, memory_tnpc} = {1'b1, taddr, tpc, tnpc};
      default: ;                                          // No report
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    test_checks++;
    assert (got === want) else begin
      $display("** Error at time %0t: test %0d %s is %h, expected %h",
               $time, test_num, name, got, want);
      errors++;
      test_errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Record replay, one record per clock cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int    fd;
    int    n;
    int    next_test;
    string line;
    idle_inputs();
    reset = 1'b0;
    fd = $fopen("btac_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file btac_testdata.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
      end
      $fclose(fd);
    end
    limit = lines.size() + 20;
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b1;
    foreach (lines[i]) begin
      @(posedge clock);
      #2;
      idle_inputs();
      n = $sscanf(lines[i],
        "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        test_num, clr_f, stl_f, get_pc0, get_pc1,
        upd_pc0, upd_npc0, upd_addr0, flags0, upd_pc1, upd_npc1, upd_addr1, flags1,
        sa, sa_taddr, sa_tpc, sa_tnpc, sb, sb_taddr, sb_tpc, sb_tnpc,
        mask, exp_branch, exp_baddr, exp_pc, exp_npc, exp_miss, exp_maddr);
      if (n != 28) begin
        $display("Record %0d could not be read, only %0d fields found", i, n);
        errors++;
        test_errors++;
        idle_inputs();
        mask = '0;
      end else begin
        clear = clr_f[0];
        stall = stl_f[0];
        {upd_jump0, upd_branch0, upd_jal0} = flags0[2:0];
        {upd_jump1, upd_branch1, upd_jal1} = flags1[2:0];
        report_stage(sa, sa_taddr, sa_tpc, sa_tnpc);
        report_stage(sb, sb_taddr, sb_tpc, sb_tnpc);
      end
      #16;                                                // Outputs settled before the edge
      if (mask[0]) check_value("pred_branch", {31'b0, pred_branch}, exp_branch);
      if (mask[1]) begin
        check_value("pred_baddr", pred_baddr, exp_baddr);
        check_value("pred_pc", pred_pc, exp_pc);
        check_value("pred_npc", pred_npc, exp_npc);
      end
      if (mask[2]) begin
        check_value("pred_miss", {31'b0, pred_miss}, exp_miss);
        check_value("pred_maddr", pred_maddr, exp_maddr);
      end
      next_test = -1;
      if (i + 1 < lines.size()) void'($sscanf(lines[i + 1], "%d", next_test));
      if (next_test != test_num) begin
        $display("Test %0d finished: %0d checks, %0d errors", test_num, test_checks,
                 test_errors);
        tests++;
        test_checks = 0;
        test_errors = 0;
      end
    end
    $display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: btac_testdata.txt
# test clr stall get_pc0 get_pc1, slot 0 pc npc addr flags, slot 1 pc npc addr flags,
# two stage reports (stage taddr tpc tnpc; stage 0 fetch .. 4 memory, 7 none), then mask
# branch baddr pc npc miss maddr. All hex; flags bit 2 jump, 1 branch, 0 jal
# mask bit 0 pred_branch, bit 1 prediction words, bit 2 pred_miss and pred_maddr
1 0 0 0 0  40 44 200 5  0 0 0 0  7 0 0 0  7 0 0 0  7 0 0 0 0 1 200
1 0 0 40 0  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 0 0 0 0 0 0
1 0 0 0 0  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 1 200 40 44 0 0
2 0 0 140 0  0 0 0 0  80 84 300 6  7 0 0 0  7 0 0 0  7 0 0 0 0 1 300
2 0 0 100 0  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 0 0 0 0 0 0
2 0 0 40 80  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 0 0 0 0 0 0
2 0 0 80 40  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 1 200 40 44 0 0
2 0 0 0 0  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 1 300 80 84 0 0
3 0 0 0 0  0 0 0 0  c0 c4 3c0 4  7 0 0 0  7 0 0 0  7 0 0 0 0 1 3c0
3 0 0 0 0  c4 c8 4c0 4  c8 cc 5c0 4  7 0 0 0  7 0 0 0  7 0 0 0 0 1 4c0
4 0 0 0 0  40 44 200 4  0 0 0 0  4 200 40 44  7 0 0 0  7 0 0 0 0 0 200
4 0 0 0 0  40 44 240 4  0 0 0 0  4 200 40 44  7 0 0 0  7 0 0 0 0 1 240
4 0 0 0 0  40 44 0 2  0 0 0 0  4 200 40 44  7 0 0 0  7 0 0 0 0 1 44
4 0 0 0 0  40 44 0 0  80 84 300 4  4 300 80 84  7 0 0 0  7 0 0 0 0 0 300
5 0 0 0 0  40 44 200 4  0 0 0 0  0 280 40 44  4 200 40 44  7 0 0 0 0 0 200
5 0 0 0 0  40 48 0 2  0 0 0 0  0 200 40 48  4 260 40 4c  7 0 0 0 0 1 4c
5 0 0 0 0  0 0 0 0  80 84 2c0 4  1 200 80 84  3 2c0 80 84  7 0 0 0 0 0 2c0
6 0 0 40 0  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 0 0 0 0 0 0
6 0 1 40 0  c4 c8 4c0 4  0 0 0 0  7 0 0 0  7 0 0 0  7 0 0 0 0 1 4c0
6 0 0 40 0  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 1 200 40 44 0 0
6 1 0 80 0  d0 d4 500 5  0 0 0 0  4 500 d0 d4  7 0 0 0  7 0 0 0 0 0 0
6 0 0 d0 0  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 1 200 40 44 0 0
6 0 0 0 0  0 0 0 0  0 0 0 0  7 0 0 0  7 0 0 0  7 0 0 0 0 0 0

// File: btb_lookup.sv
`timescale 1ns/1ps

module btb_lookup (
  input  logic [95:0] rdata0,
  input  logic [95:0] rdata1,
  input  logic [31:0] pc0_q,
  input  logic [31:0] pc1_q,
  output logic        hit0,
  output logic        hit1,
  output logic [31:0] sel_baddr,
  output logic [31:0] sel_pc,
  output logic [31:0] sel_npc
);

  logic [btac_pkg::entry_width-1:0] sel_entry;

  function automatic logic entry_hit(
    input logic [btac_pkg::entry_width-1:0] entry,
    input logic [btac_pkg::word_width-1:0]  pc
  );
    logic [btac_pkg::word_width-1:0] tag;
    tag = entry[btac_pkg::pc_lsb +: btac_pkg::word_width];
    // Empty slot never matches, even for pc zero
    return (|entry) && (tag == pc);
  endfunction

  assign hit0 = entry_hit(rdata0, pc0_q);
  assign hit1 = entry_hit(rdata1, pc1_q);

  assign sel_entry = hit0 ? rdata0 : rdata1;   // Slot 0 wins

  assign sel_baddr = sel_entry[btac_pkg::target_lsb +: btac_pkg::word_width];
  assign sel_pc    = sel_entry[btac_pkg::pc_lsb +: btac_pkg::word_width];
  assign sel_npc   = sel_entry[btac_pkg::npc_lsb +: btac_pkg::word_width];

endmodule

// File: btb_ram.sv
`timescale 1ns/1ps

module btb_ram (
  input  logic        clock,
  input  logic        wen,
  input  logic [5:0]  waddr,
  input  logic [5:0]  raddr0,
  input  logic [5:0]  raddr1,
  input  logic [95:0] wdata,
  output logic [95:0] rdata0,
  output logic [95:0] rdata1
);

  logic [btac_pkg::entry_width-1:0] entries [0:btac_pkg::btb_entries-1] = '{default: '0};

  logic [btac_pkg::btb_index_width-1:0] raddr0_q = '0;
  logic [btac_pkg::btb_index_width-1:0] raddr1_q = '0;

  always_ff @(posedge clock) begin
    raddr0_q <= raddr0;                 // Read address latched here
    raddr1_q <= raddr1;
    if (wen) begin
      entries[waddr] <= wdata;
    end
  end

  // Asynchronous read on the latched index gives one cycle latency
  assign rdata0 = entries[raddr0_q];
  assign rdata1 = entries[raddr1_q];

endmodule

// File: miss_resolver.sv
`timescale 1ns/1ps

module miss_resolver (
  input  logic                     clear,
  input  logic                     cand_taken,
  input  logic [31:0]              cand_taddr,
  input  logic [31:0]              cand_tpc,
  input  logic [31:0]              cand_tnpc,
  input  btac_pkg::tracker_state_t state,
  input  logic [31:0]              upd_pc0,
  input  logic [31:0]              upd_pc1,
  input  logic [31:0]              upd_addr0,
  input  logic [31:0]              upd_addr1,
  input  logic                     upd_jump0,
  input  logic                     upd_jump1,
  input  logic                     upd_branch0,
  input  logic                     upd_branch1,
  output logic                     pred_miss,
  output logic [31:0]              pred_maddr,
  output btac_pkg::resolve_kind_t  kind
);

  logic        match0;
  logic        match1;
  logic        m_jump;
  logic        m_branch;
  logic [31:0] m_addr;

  assign match0 = cand_taken && (upd_pc0 == cand_tpc);
  assign match1 = cand_taken && (upd_pc1 == cand_tpc);

  // Slot holding the tracked branch
  assign m_jump   = match0 ? upd_jump0   : upd_jump1;
  assign m_branch = match0 ? upd_branch0 : upd_branch1;
  assign m_addr   = match0 ? upd_addr0   : upd_addr1;

  always_comb begin
    pred_miss  = 1'b0;
    pred_maddr = '0;
    kind       = btac_pkg::res_none;
    if (!clear) begin
      if (match0 || match1) begin
        if (m_jump) begin
          pred_maddr = m_addr;
          if (m_addr != cand_taddr) begin
            pred_miss = 1'b1;
            kind      = btac_pkg::res_wrong_target;
          end else begin
            kind = btac_pkg::res_confirm;
          end
        end else if (m_branch) begin
          pred_miss  = 1'b1;            // Fall through after all
          pred_maddr = cand_tnpc;
          kind       = btac_pkg::res_not_taken;
        end
      end else if (upd_jump0) begin
        pred_miss  = 1'b1;
        pred_maddr = upd_addr0;
        kind       = btac_pkg::res_unpredicted;
      end else if (upd_jump1) begin
        pred_miss  = 1'b1;
        pred_maddr = upd_addr1;
        kind       = btac_pkg::res_unpredicted;
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module btac_tb -f vlog.f -o btac_sim

status=0
out=$(./obj_dir/btac_sim) || status=$?
printf '%s\n' "$out"
[ "$status" -eq 0 ] || exit 1
printf '%s\n' "$out" | grep -qx "All checks passed"

// File: taken_tracker.sv
`timescale 1ns/1ps

module taken_tracker (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     clear,
  input  logic                     fetch_taken,
  input  logic [31:0]              fetch_taddr,
  input  logic [31:0]              fetch_tpc,
  input  logic [31:0]              fetch_tnpc,
  input  logic                     decode_taken,
  input  logic [31:0]              decode_taddr,
  input  logic [31:0]              decode_tpc,
  input  logic [31:0]              decode_tnpc,
  input  logic                     issue_taken,
  input  logic [31:0]              issue_taddr,
  input  logic [31:0]              issue_tpc,
  input  logic [31:0]              issue_tnpc,
  input  logic                     execute_taken,
  input  logic [31:0]              execute_taddr,
  input  logic [31:0]              execute_tpc,
  input  logic [31:0]              execute_tnpc,
  input  logic                     memory_taken,
  input  logic [31:0]              memory_taddr,
  input  logic [31:0]              memory_tpc,
  input  logic [31:0]              memory_tnpc,
  input  logic [31:0]              upd_pc0,
  input  logic [31:0]              upd_pc1,
  input  btac_pkg::resolve_kind_t  kind,
  output logic                     cand_taken,
  output logic [31:0]              cand_taddr,
  output logic [31:0]              cand_tpc,
  output logic [31:0]              cand_tnpc,
  output btac_pkg::tracker_state_t state
);

  logic [31:0] taddr_q;
  logic [31:0] tpc_q;
  logic [31:0] tnpc_q;

  // Stage report is relevant only for a pc now being updated
  function automatic logic stage_hit(input logic taken, input logic [31:0] tpc,
                                     input logic [31:0] pc0, input logic [31:0] pc1);
    return taken && ((tpc == pc0) || (tpc == pc1));
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Candidate record, oldest stage first
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    cand_taken = 1'b0;
    cand_taddr = '0;
    cand_tpc   = '0;
    cand_tnpc  = '0;
    if (!clear) begin
      cand_taken = 1'b1;
      if (stage_hit(memory_taken, memory_tpc, upd_pc0, upd_pc1)) begin
        {cand_taddr, cand_tpc, cand_tnpc} = {memory_taddr, memory_tpc, memory_tnpc};
      end else if (stage_hit(execute_taken, execute_tpc, upd_pc0, upd_pc1)) begin
        {cand_taddr, cand_tpc, cand_tnpc} = {execute_taddr, execute_tpc, execute_tnpc};
      end else if (stage_hit(issue_taken, issue_tpc, upd_pc0, upd_pc1)) begin
        {cand_taddr, cand_tpc, cand_tnpc} = {issue_taddr, issue_tpc, issue_tnpc};
      end else if (stage_hit(decode_taken, decode_tpc, upd_pc0, upd_pc1)) begin
        {cand_taddr, cand_tpc, cand_tnpc} = {decode_taddr, decode_tpc, decode_tnpc};
      end else if (stage_hit(fetch_taken, fetch_tpc, upd_pc0, upd_pc1)) begin
        {cand_taddr, cand_tpc, cand_tnpc} = {fetch_taddr, fetch_tpc, fetch_tnpc};
      end else begin
        cand_taken = (state == btac_pkg::trk_armed);   // Held record
        {cand_taddr, cand_tpc, cand_tnpc} = {taddr_q, tpc_q, tnpc_q};
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      state   <= btac_pkg::trk_idle;
      taddr_q <= '0;
      tpc_q   <= '0;
      tnpc_q  <= '0;
    end else begin
      // Any verdict retires the record
      if (cand_taken && (kind == btac_pkg::res_none)) begin
        state <= btac_pkg::trk_armed;
      end else begin
        state <= btac_pkg::trk_idle;
      end
      taddr_q <= cand_taddr;
      tpc_q   <= cand_tpc;
      tnpc_q  <= cand_tnpc;
    end
  end

endmodule

// File: vlog.f
btac_pkg.sv
btb_ram.sv
btb_lookup.sv
taken_tracker.sv
miss_resolver.sv
btac_ctrl.sv
btac.sv
btac_assert.sv
btac_tb.sv
